// ==== hw/cgra_settings.svh ====
`ifndef CGRA_SETTINGS_SVH
`define CGRA_SETTINGS_SVH

// memory and stream widths.
`define CGRA_MEM_W 64
`define CGRA_ELEM_W 16
`define CGRA_ELEMS 4
`define CGRA_CHANNELS 2

// configuration word fields, the rest of the word is ignored.
`define CGRA_OP0_BITS 1:0
`define CGRA_OP1_BITS 3:2
`define CGRA_RMASK_BITS 5:4
`define CGRA_WMASK_BITS 7:6
`define CGRA_CONST0_BITS 23:8
`define CGRA_CONST1_BITS 39:24

`endif

// ==== hw/cgra_data_pkg.sv ====
`include "cgra_settings.svh"

package cgra_data_pkg;

  // one memory transfer.
  typedef logic [`CGRA_MEM_W-1:0] mem_word_t;

  // one stream element.
  typedef logic [`CGRA_ELEM_W-1:0] elem_t;

  // one bit per memory channel, also one bit per lane.
  typedef logic [`CGRA_CHANNELS-1:0] chan_mask_t;

  // number of elements held in a word, 0 up to a full word.
  typedef logic [$clog2(`CGRA_ELEMS+1)-1:0] elem_cnt_t;

endpackage

// ==== hw/cgra_conf_pkg.sv ====
`include "cgra_settings.svh"

package cgra_conf_pkg;

  typedef logic [`CGRA_MEM_W-1:0] conf_word_t;

  // lane operation, applied with the lane constant.
  typedef enum logic [1:0] {
    OP_PASS = 2'd0,
    OP_ADD  = 2'd1,
    OP_SUB  = 2'd2,
    OP_MUL  = 2'd3
  } lane_op_t;

  typedef enum logic [1:0] {
    CONF_IDLE,
    CONF_REQ,
    CONF_WAIT,
    CONF_DONE
  } conf_state_t;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_RUN,
    EXEC_DRAIN,
    EXEC_DONE
  } exec_state_t;

endpackage

// ==== hw/fetch_data.sv ====
`timescale 1ns/1ns
`include "cgra_settings.svh"

module fetch_data (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     en,
  input  logic                     available_read,
  output logic                     request_read,
  input  logic                     data_valid,
  input  cgra_data_pkg::mem_word_t read_data,
  input  logic                     pop_data,
  output logic                     available_pop,
  output cgra_data_pkg::elem_t     data_out
);

  import cgra_data_pkg::*;

  mem_word_t word_q;
  elem_cnt_t remain_q;
  logic      pending_q;
  logic      empty;

  assign empty         = remain_q == '0;
  assign available_pop = !empty;
  assign data_out      = word_q[`CGRA_ELEM_W-1:0];

  // at most one read in flight, and none until the held word is used up.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      request_read <= 1'b0;
      pending_q    <= 1'b0;
      remain_q     <= '0;
    end else begin
      request_read <= 1'b0;
      if (pending_q && data_valid) begin
        pending_q <= 1'b0;
        remain_q  <= elem_cnt_t'(`CGRA_ELEMS);
      end else if (pop_data) begin
        remain_q <= remain_q - 1'b1;
      end else if (!en) begin
        pending_q <= 1'b0;
      end else if (empty && !pending_q && available_read) begin
        request_read <= 1'b1;
        pending_q    <= 1'b1;
      end
    end
  end

  // element 0 sits in the low bits and leaves first.
  always_ff @(posedge clk) begin
    if (pending_q && data_valid) begin
      word_q <= read_data;
    end else if (pop_data) begin
      word_q <= word_q >> `CGRA_ELEM_W;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) pop_data |-> available_pop)
    else $error("fetch_data: pop with no element held");

endmodule

// ==== hw/dispatch_data.sv ====
`timescale 1ns/1ns
`include "cgra_settings.svh"

module dispatch_data (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     available_write,
  output logic                     request_write,
  output cgra_data_pkg::mem_word_t write_data,
  input  logic                     push_data,
  output logic                     available_push,
  input  cgra_data_pkg::elem_t     data_in
);

  import cgra_data_pkg::*;

  mem_word_t pack_q;
  elem_cnt_t count_q;
  logic      full;

  assign full           = count_q == elem_cnt_t'(`CGRA_ELEMS);
  assign available_push = !full;
  assign request_write  = full && available_write;
  assign write_data     = pack_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (request_write) begin
      count_q <= '0;
    end else if (push_data) begin
      count_q <= count_q + 1'b1;
    end
  end

  // new elements enter at the top, so the first one ends in the low bits.
  always_ff @(posedge clk) begin
    if (push_data) begin
      pack_q <= {data_in, pack_q[`CGRA_MEM_W-1:`CGRA_ELEM_W]};
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) push_data |-> !full)
    else $error("dispatch_data: push into a full word");

endmodule

// ==== hw/cgra_control_conf.sv ====
`timescale 1ns/1ns
`include "cgra_settings.svh"

module cgra_control_conf (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       start,
  input  logic                       available_read,
  output logic                       req_rd_data,
  input  logic                       rd_data_valid,
  input  cgra_data_pkg::mem_word_t   rd_data,
  output cgra_conf_pkg::lane_op_t    lane_op0,
  output cgra_conf_pkg::lane_op_t    lane_op1,
  output cgra_data_pkg::elem_t       lane_const0,
  output cgra_data_pkg::elem_t       lane_const1,
  output cgra_data_pkg::chan_mask_t  read_fifo_mask,
  output cgra_data_pkg::chan_mask_t  write_fifo_mask,
  output logic                       done
);

  import cgra_conf_pkg::*;

  conf_state_t state_q;
  conf_word_t  conf_w;
  logic        load;

  assign conf_w      = rd_data;
  assign load        = (state_q == CONF_WAIT) && rd_data_valid;
  assign req_rd_data = (state_q == CONF_REQ) && available_read;
  assign done        = state_q == CONF_DONE;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q         <= CONF_IDLE;
      lane_op0        <= OP_PASS;
      lane_op1        <= OP_PASS;
      read_fifo_mask  <= '0;
      write_fifo_mask <= '0;
    end else begin
      unique case (state_q)
        CONF_IDLE: if (start) state_q <= CONF_REQ;
        CONF_REQ:  if (available_read) state_q <= CONF_WAIT;
        CONF_WAIT: if (rd_data_valid) state_q <= CONF_DONE;
        CONF_DONE: state_q <= CONF_IDLE;
      endcase
      if (load) begin
        lane_op0        <= lane_op_t'(conf_w[`CGRA_OP0_BITS]);
        lane_op1        <= lane_op_t'(conf_w[`CGRA_OP1_BITS]);
        read_fifo_mask  <= conf_w[`CGRA_RMASK_BITS];
        write_fifo_mask <= conf_w[`CGRA_WMASK_BITS];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      lane_const0 <= conf_w[`CGRA_CONST0_BITS];
      lane_const1 <= conf_w[`CGRA_CONST1_BITS];
    end
  end

endmodule

// ==== hw/cgra_control_exec.sv ====
`timescale 1ns/1ns

module cgra_control_exec (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       start,
  input  cgra_data_pkg::chan_mask_t  fetch_empty,
  input  cgra_data_pkg::chan_mask_t  read_fifo_mask,
  input  cgra_data_pkg::chan_mask_t  write_fifo_mask,
  input  cgra_data_pkg::chan_mask_t  read_fifo_done,
  input  cgra_data_pkg::chan_mask_t  write_fifo_done,
  output cgra_data_pkg::chan_mask_t  en_fetch,
  output cgra_data_pkg::chan_mask_t  en_lane,
  output logic                       done
);

  import cgra_data_pkg::*;
  import cgra_conf_pkg::*;

  exec_state_t state_q;
  chan_mask_t  rd_open;
  chan_mask_t  wr_open;
  logic        active;

  // a channel stays open until the host is done with it and nothing is left here.
  assign rd_open = read_fifo_mask & ~(read_fifo_done & fetch_empty);
  assign wr_open = write_fifo_mask & ~write_fifo_done;

  assign active   = (state_q == EXEC_RUN) || (state_q == EXEC_DRAIN);
  assign en_fetch = (state_q == EXEC_RUN) ? read_fifo_mask : '0;
  assign en_lane  = active ? (read_fifo_mask & write_fifo_mask) : '0;
  assign done     = state_q == EXEC_DONE;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= EXEC_IDLE;
    end else begin
      unique case (state_q)
        EXEC_IDLE: begin
          if (start) state_q <= EXEC_RUN;
        end
        EXEC_RUN: begin
          if (rd_open == '0 && wr_open == '0) begin
            state_q <= EXEC_DONE;
          end else if (rd_open == '0) begin
            state_q <= EXEC_DRAIN;
          end
        end
        EXEC_DRAIN: begin
          if (wr_open == '0) state_q <= EXEC_DONE;
        end
        EXEC_DONE: state_q <= EXEC_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/cgra_core.sv ====
`timescale 1ns/1ns
`include "cgra_settings.svh"

module cgra_core (
  input  logic                       clk,
  input  logic                       arst_n,
  input  cgra_data_pkg::chan_mask_t  en_lane,
  input  cgra_data_pkg::chan_mask_t  available_pop,
  output cgra_data_pkg::chan_mask_t  pop_data,
  input  cgra_data_pkg::elem_t       fifo_in_data0,
  input  cgra_data_pkg::elem_t       fifo_in_data1,
  input  cgra_data_pkg::chan_mask_t  available_push,
  output cgra_data_pkg::chan_mask_t  push_data,
  output cgra_data_pkg::elem_t       fifo_out_data0,
  output cgra_data_pkg::elem_t       fifo_out_data1,
  input  cgra_conf_pkg::lane_op_t    lane_op0,
  input  cgra_conf_pkg::lane_op_t    lane_op1,
  input  cgra_data_pkg::elem_t       lane_const0,
  input  cgra_data_pkg::elem_t       lane_const1
);

  import cgra_data_pkg::*;
  import cgra_conf_pkg::*;

  elem_t    in_data  [`CGRA_CHANNELS];
  elem_t    out_data [`CGRA_CHANNELS];
  elem_t    cst      [`CGRA_CHANNELS];
  lane_op_t op       [`CGRA_CHANNELS];

  assign in_data[0]     = fifo_in_data0;
  assign in_data[1]     = fifo_in_data1;
  assign cst[0]         = lane_const0;
  assign cst[1]         = lane_const1;
  assign op[0]          = lane_op0;
  assign op[1]          = lane_op1;
  assign fifo_out_data0 = out_data[0];
  assign fifo_out_data1 = out_data[1];

  // --------------------------------------------------------------------------
  // lanes, one result register each.
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < `CGRA_CHANNELS; i++) begin : g_lane
    elem_t res;
    elem_t res_q;
    logic  res_valid_q;

    always_comb begin
      unique case (op[i])
        OP_PASS: res = in_data[i];
        OP_ADD:  res = in_data[i] + cst[i];
        OP_SUB:  res = in_data[i] - cst[i];
        OP_MUL:  res = in_data[i] * cst[i];
      endcase
    end

    // a full dispatch unit stalls both the pop and the push.
    assign pop_data[i]  = en_lane[i] & available_pop[i] & available_push[i];
    assign push_data[i] = res_valid_q & available_push[i];
    assign out_data[i]  = res_q;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        res_valid_q <= 1'b0;
      end else if (pop_data[i]) begin
        res_valid_q <= 1'b1;
      end else if (push_data[i]) begin
        res_valid_q <= 1'b0;
      end
    end

    always_ff @(posedge clk) begin
      if (pop_data[i]) begin
        res_q <= res;
      end
    end
  end

endmodule

// ==== hw/cgra_acc.sv ====
`timescale 1ns/1ns
`include "cgra_settings.svh"

module cgra_acc (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       start,
  input  cgra_data_pkg::chan_mask_t  done_rd_data,
  input  cgra_data_pkg::chan_mask_t  done_wr_data,
  input  cgra_data_pkg::chan_mask_t  available_read,
  output cgra_data_pkg::chan_mask_t  request_read,
  input  cgra_data_pkg::chan_mask_t  read_data_valid,
  input  cgra_data_pkg::mem_word_t   read_data0,
  input  cgra_data_pkg::mem_word_t   read_data1,
  input  cgra_data_pkg::chan_mask_t  available_write,
  output cgra_data_pkg::chan_mask_t  request_write,
  output cgra_data_pkg::mem_word_t   write_data0,
  output cgra_data_pkg::mem_word_t   write_data1,
  output logic                       done
);

  import cgra_data_pkg::*;
  import cgra_conf_pkg::*;

  mem_word_t  rd_word    [`CGRA_CHANNELS];
  mem_word_t  wr_word    [`CGRA_CHANNELS];
  elem_t      fetch_elem [`CGRA_CHANNELS];
  elem_t      core_elem  [`CGRA_CHANNELS];
  chan_mask_t fetch_req;
  chan_mask_t en_fetch;
  chan_mask_t en_lane;
  chan_mask_t pop_data;
  chan_mask_t available_pop;
  chan_mask_t push_data;
  chan_mask_t available_push;
  chan_mask_t read_fifo_mask;
  chan_mask_t write_fifo_mask;
  lane_op_t   lane_op0;
  lane_op_t   lane_op1;
  elem_t      lane_const0;
  elem_t      lane_const1;
  logic       conf_req;
  logic       conf_done;

  assign rd_word[0]   = read_data0;
  assign rd_word[1]   = read_data1;
  assign write_data0  = wr_word[0];
  assign write_data1  = wr_word[1];

  // channel 0 carries the configuration read before any data read.
  assign request_read = {fetch_req[1], fetch_req[0] | conf_req};

  // --------------------------------------------------------------------------
  // memory side, one fetch and one dispatch unit per channel.
  // --------------------------------------------------------------------------
  for (genvar ch = 0; ch < `CGRA_CHANNELS; ch++) begin : g_chan
    fetch_data u_fetch (
      .clk            (clk),
      .arst_n         (arst_n),
      .en             (en_fetch[ch]),
      .available_read (available_read[ch]),
      .request_read   (fetch_req[ch]),
      .data_valid     (read_data_valid[ch]),
      .read_data      (rd_word[ch]),
      .pop_data       (pop_data[ch]),
      .available_pop  (available_pop[ch]),
      .data_out       (fetch_elem[ch])
    );

    dispatch_data u_dispatch (
      .clk             (clk),
      .arst_n          (arst_n),
      .available_write (available_write[ch]),
      .request_write   (request_write[ch]),
      .write_data      (wr_word[ch]),
      .push_data       (push_data[ch]),
      .available_push  (available_push[ch]),
      .data_in         (core_elem[ch])
    );
  end

  // --------------------------------------------------------------------------
  // control and compute.
  // --------------------------------------------------------------------------
  cgra_control_conf u_control_conf (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (start),
    .available_read  (available_read[0]),
    .req_rd_data     (conf_req),
    .rd_data_valid   (read_data_valid[0]),
    .rd_data         (read_data0),
    .lane_op0        (lane_op0),
    .lane_op1        (lane_op1),
    .lane_const0     (lane_const0),
    .lane_const1     (lane_const1),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .done            (conf_done)
  );

  cgra_control_exec u_control_exec (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (conf_done),
    .fetch_empty     (~available_pop),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .read_fifo_done  (done_rd_data),
    .write_fifo_done (done_wr_data),
    .en_fetch        (en_fetch),
    .en_lane         (en_lane),
    .done            (done)
  );

  cgra_core u_core (
    .clk            (clk),
    .arst_n         (arst_n),
    .en_lane        (en_lane),
    .available_pop  (available_pop),
    .pop_data       (pop_data),
    .fifo_in_data0  (fetch_elem[0]),
    .fifo_in_data1  (fetch_elem[1]),
    .available_push (available_push),
    .push_data      (push_data),
    .fifo_out_data0 (core_elem[0]),
    .fifo_out_data1 (core_elem[1]),
    .lane_op0       (lane_op0),
    .lane_op1       (lane_op1),
    .lane_const0    (lane_const0),
    .lane_const1    (lane_const1)
  );

  // the configuration read and the data reads share channel 0.
  assert property (@(posedge clk) disable iff (!arst_n) !(conf_req && fetch_req[0]))
    else $error("cgra_acc: two read requests on channel 0");

endmodule

// ==== verification/cgra_acc_tb.sv ====
`timescale 1ns/1ns
`include "cgra_settings.svh"

module cgra_acc_tb;

  import cgra_data_pkg::*;
  import cgra_conf_pkg::*;

  localparam int NUM_ROWS     = 4;
  localparam int WORDS        = 2;
  localparam int DONE_TIMEOUT = 500;
  localparam int QUIET_CYCLES = 8;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       start;
  chan_mask_t done_rd_data;
  chan_mask_t done_wr_data;
  chan_mask_t available_read;
  chan_mask_t request_read;
  chan_mask_t read_data_valid;
  mem_word_t  read_data0;
  mem_word_t  read_data1;
  chan_mask_t available_write;
  chan_mask_t request_write;
  mem_word_t  write_data0;
  mem_word_t  write_data1;
  logic       done;

  integer seed = 35759;

  // scenario table with one row per run.
  lane_op_t   tbl_op0   [NUM_ROWS];
  lane_op_t   tbl_op1   [NUM_ROWS];
  elem_t      tbl_c0    [NUM_ROWS];
  elem_t      tbl_c1    [NUM_ROWS];
  chan_mask_t tbl_rmask [NUM_ROWS];
  chan_mask_t tbl_wmask [NUM_ROWS];
  mem_word_t  tbl_data  [NUM_ROWS][`CGRA_CHANNELS][WORDS];

  // host memory model state for the row in progress.
  mem_word_t rd_word       [`CGRA_CHANNELS][WORDS+1];
  int        rd_total      [`CGRA_CHANNELS];
  int        rd_req        [`CGRA_CHANNELS];
  int        rd_ret        [`CGRA_CHANNELS];
  int        resp_wait     [`CGRA_CHANNELS];
  logic      resp_busy     [`CGRA_CHANNELS];
  mem_word_t exp_word      [`CGRA_CHANNELS][WORDS];
  int        exp_writes    [`CGRA_CHANNELS];
  int        wr_seen       [`CGRA_CHANNELS];
  int        done_seen;
  logic      conf_returned;

  always #2 clk = ~clk;

  cgra_acc UUT (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (start),
    .done_rd_data    (done_rd_data),
    .done_wr_data    (done_wr_data),
    .available_read  (available_read),
    .request_read    (request_read),
    .read_data_valid (read_data_valid),
    .read_data0      (read_data0),
    .read_data1      (read_data1),
    .available_write (available_write),
    .request_write   (request_write),
    .write_data0     (write_data0),
    .write_data1     (write_data1),
    .done            (done)
  );

  // --------------------------------------------------------------------------
  // reference model and checks.
  // --------------------------------------------------------------------------
  function automatic elem_t lane_result(lane_op_t op, elem_t x, elem_t c);
    logic [31:0] prod;
    prod = x * c;
    case (op)
      OP_PASS: return x;
      OP_ADD:  return x + c;
      OP_SUB:  return x - c;
      default: return prod[15:0];
    endcase
  endfunction

  // element k lives in bits 16k+15 to 16k.
  function automatic mem_word_t expected_word(lane_op_t op, elem_t c, mem_word_t w);
    mem_word_t r;
    r = '0;
    for (int k = 0; k < `CGRA_ELEMS; k++) begin
      r[16*k +: 16] = lane_result(op, w[16*k +: 16], c);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("ERROR: time %0t ns, %s: got 0x%0h, expected 0x%0h",
               $time, name, got, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  // --------------------------------------------------------------------------
  // host memory model that runs once per rising edge.
  // --------------------------------------------------------------------------
  task automatic service_host();
    int        ch;
    mem_word_t got;
    read_data_valid <= '0;
    available_write <= chan_mask_t'($random(seed));
    if (done) begin
      done_seen++;
      check_value("done pulse count", 64'(done_seen), 64'd1);
      for (ch = 0; ch < `CGRA_CHANNELS; ch++) begin
        check_value($sformatf("writes before done ch%0d", ch), 64'(wr_seen[ch]),
                    64'(exp_writes[ch]));
      end
    end
    for (ch = 0; ch < `CGRA_CHANNELS; ch++) begin
      if (request_read[ch]) begin
        if (rd_req[ch] >= rd_total[ch])
          stop_with_failure($sformatf("request_read on channel %0d with no word to send", ch));
        if (resp_busy[ch])
          stop_with_failure($sformatf("second read outstanding on channel %0d", ch));
        if (ch == 1 && !conf_returned)
          stop_with_failure("channel 1 read requested before the configuration word");
        resp_busy[ch] = 1'b1;
        resp_wait[ch] = 1 + {$random(seed)} % 3;
        rd_req[ch]++;
        if (rd_req[ch] == rd_total[ch]) available_read[ch] <= 1'b0;
      end
      if (resp_busy[ch]) begin
        resp_wait[ch]--;
        if (resp_wait[ch] == 0) begin
          resp_busy[ch] = 1'b0;
          read_data_valid[ch] <= 1'b1;
          if (ch == 0) read_data0 <= rd_word[0][rd_ret[0]];
          else read_data1 <= rd_word[1][rd_ret[1]];
          rd_ret[ch]++;
          if (ch == 0) conf_returned = 1'b1;
        end
      end else if (rd_ret[ch] == rd_total[ch]) begin
        done_rd_data[ch] <= 1'b1;
      end
      if (request_write[ch]) begin
        if (wr_seen[ch] >= exp_writes[ch])
          stop_with_failure($sformatf("unexpected request_write on channel %0d", ch));
        got = (ch == 0) ? write_data0 : write_data1;
        check_value($sformatf("write_data%0d word %0d", ch, wr_seen[ch]), got,
                    exp_word[ch][wr_seen[ch]]);
        wr_seen[ch]++;
        if (wr_seen[ch] == exp_writes[ch]) done_wr_data[ch] <= 1'b1;
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    start <= 1'b0;
    service_host();
  endtask

  // --------------------------------------------------------------------------
  // scenario table.
  // --------------------------------------------------------------------------
  task automatic set_row(input int r, input lane_op_t op0, input lane_op_t op1,
                         input elem_t c0, input elem_t c1, input chan_mask_t mask);
    tbl_op0[r]   = op0;
    tbl_op1[r]   = op1;
    tbl_c0[r]    = c0;
    tbl_c1[r]    = c1;
    tbl_rmask[r] = mask;
    tbl_wmask[r] = mask;
  endtask

  task automatic build_table();
    set_row(0, OP_PASS, OP_ADD,  16'h1234, 16'h8001, 2'b11);
    set_row(1, OP_SUB,  OP_MUL,  16'h0101, 16'h0007, 2'b11);
    set_row(2, OP_MUL,  OP_SUB,  16'hfffd, 16'hff00, 2'b01);
    set_row(3, OP_ADD,  OP_PASS, 16'hffff, 16'h5a5a, 2'b11);
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int ch = 0; ch < `CGRA_CHANNELS; ch++) begin
        for (int w = 0; w < WORDS; w++) begin
          tbl_data[r][ch][w] = {$random(seed), $random(seed)};
        end
      end
    end
  endtask

  task automatic load_row(input int r);
    mem_word_t conf;
    lane_op_t  op;
    elem_t     c;
    // upper bits carry noise that the DUT must ignore.
    conf = {24'($random(seed)), tbl_c1[r], tbl_c0[r], tbl_wmask[r], tbl_rmask[r],
            tbl_op1[r], tbl_op0[r]};
    for (int ch = 0; ch < `CGRA_CHANNELS; ch++) begin
      rd_total[ch]   = 0;
      rd_req[ch]     = 0;
      rd_ret[ch]     = 0;
      resp_busy[ch]  = 1'b0;
      wr_seen[ch]    = 0;
      exp_writes[ch] = 0;
    end
    rd_word[0][0] = conf;
    rd_total[0]   = 1;
    for (int ch = 0; ch < `CGRA_CHANNELS; ch++) begin
      op = (ch == 0) ? tbl_op0[r] : tbl_op1[r];
      c  = (ch == 0) ? tbl_c0[r] : tbl_c1[r];
      for (int w = 0; w < WORDS; w++) begin
        if (tbl_rmask[r][ch]) begin
          rd_word[ch][rd_total[ch]] = tbl_data[r][ch][w];
          rd_total[ch]++;
        end
        if (tbl_rmask[r][ch] && tbl_wmask[r][ch]) begin
          exp_word[ch][w] = expected_word(op, c, tbl_data[r][ch][w]);
          exp_writes[ch]++;
        end
      end
      available_read[ch] <= 1'b1;
      done_rd_data[ch]   <= rd_total[ch] == 0;
      done_wr_data[ch]   <= exp_writes[ch] == 0;
    end
    done_seen     = 0;
    conf_returned = 1'b0;
  endtask

  task automatic check_reset_values();
    check_value("request_read", 64'(request_read), 64'd0);
    check_value("request_write", 64'(request_write), 64'd0);
    check_value("done", 64'(done), 64'd0);
    check_value("en_fetch", 64'(UUT.en_fetch), 64'd0);
    check_value("en_lane", 64'(UUT.en_lane), 64'd0);
    check_value("available_pop", 64'(UUT.available_pop), 64'd0);
    check_value("available_push", 64'(UUT.available_push), 64'd3);
  endtask

  task automatic wait_for_done(input int r);
    int cycles;
    cycles = 0;
    while (done_seen == 0) begin
      if (cycles == DONE_TIMEOUT)
        stop_with_failure($sformatf("timeout waiting for done in row %0d", r));
      next_cycle();
      cycles++;
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence.
  // --------------------------------------------------------------------------
  initial begin
    arst_n          <= 1'b0;
    start           <= 1'b0;
    done_rd_data    <= '0;
    done_wr_data    <= '0;
    available_read  <= '0;
    read_data_valid <= '0;
    read_data0      <= '0;
    read_data1      <= '0;
    available_write <= '0;
    for (int ch = 0; ch < `CGRA_CHANNELS; ch++) begin
      rd_total[ch]   = 0;
      rd_req[ch]     = 0;
      rd_ret[ch]     = 0;
      resp_busy[ch]  = 1'b0;
      resp_wait[ch]  = 0;
      exp_writes[ch] = 0;
      wr_seen[ch]    = 0;
    end
    done_seen     = 0;
    conf_returned = 1'b0;
    build_table();

    for (int i = 0; i < 3; i++) next_cycle();
    arst_n <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      check_reset_values();
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      next_cycle();
      load_row(r);
      start <= 1'b1;
      wait_for_done(r);
      // a second done pulse in this window fails in the host model.
      for (int i = 0; i < QUIET_CYCLES; i++) next_cycle();
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/cgra_data_pkg.sv
hw/cgra_conf_pkg.sv
hw/fetch_data.sv
hw/dispatch_data.sv
hw/cgra_control_conf.sv
hw/cgra_control_exec.sv
hw/cgra_core.sv
hw/cgra_acc.sv
verification/cgra_acc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cgra_acc testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cgra_acc_tb -f filelist.f -o cgra_acc_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/cgra_acc_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

exit 0
